/* verification/lc4_checker.sv */
// ------------------------------------------------
// retirement checker: isa-level model of the lc4
// subset, compared against the trace outputs
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_checker
    import lc4_pkg::*;
#(
    parameter word_t RESET_PC = 16'h8200
) (
    input logic     gwe,
    input logic     i_reset,
    input logic     i_imem_req,
    input logic     i_retire,
    input word_t    i_retire_pc,
    input word_t    i_retire_insn,
    input logic     i_rf_we,
    input reg_idx_t i_rf_wsel,
    input word_t    i_rf_data,
    input logic     i_nzp_we,
    input nzp_t     i_nzp_bits,
    input word_t    i_program [64]
);
    string test_name = "";
    int    retired   = 0;
    int    errors    = 0;

    // architectural state of the model
    word_t model_regs [8];
    nzp_t  model_nzp;
    word_t model_pc;

    // reset as the core saw it at the last rising edge
    logic  reset_seen;

    // packed result {rf_we, wsel, data, nzp_we, nzp, next_pc}
    function automatic logic [39:0] predict(input word_t insn, input word_t pc,
                                            input word_t a, input word_t b,
                                            input word_t d, input nzp_t nzp);
        logic     we;
        reg_idx_t sel;
        word_t    res;
        word_t    npc;
        word_t    sext5;
        word_t    sext9;
        word_t    sext11;
        sext5  = {{11{insn[4]}}, insn[4:0]};
        sext9  = {{7{insn[8]}}, insn[8:0]};
        sext11 = {{5{insn[10]}}, insn[10:0]};
        npc    = pc + 16'd1;
        we     = 1'b0;
        res    = '0;
        sel    = insn[RD_MSB -: 3];
        case (insn[INSN_OP_MSB -: 4])
            4'b0000: begin
                // br, a zero mask never matches
                if ((insn[11:9] & nzp) != 3'b000) begin
                    npc = pc + 16'd1 + sext9;
                end
            end
            4'b0001: begin
                if (insn[5]) begin
                    res = a + sext5;
                    we  = 1'b1;
                end else begin
                    case (insn[5:3])
                        3'd0: begin res = a + b; we = 1'b1; end
                        3'd1: begin res = a * b; we = 1'b1; end
                        3'd2: begin res = a - b; we = 1'b1; end
                        default: we = 1'b0;
                    endcase
                end
            end
            4'b0101: begin
                case (insn[5:3])
                    3'd0: begin res = a & b; we = 1'b1; end
                    3'd1: begin res = ~a;    we = 1'b1; end
                    3'd2: begin res = a | b; we = 1'b1; end
                    3'd3: begin res = a ^ b; we = 1'b1; end
                    default: we = 1'b0;
                endcase
            end
            4'b1001: begin
                res = sext9;
                we  = 1'b1;
            end
            4'b1101: begin
                if (insn[8]) begin
                    res = {insn[7:0], d[7:0]};
                    we  = 1'b1;
                end
            end
            4'b1100: begin
                if (insn[11]) begin
                    npc = pc + 16'd1 + sext11;
                end
            end
            default: we = 1'b0;
        endcase
        return {we, sel, res, we, nzp_of(res), npc};
    endfunction

    // memory image as seen by the core, zero outside the program
    function automatic word_t program_word(input word_t pc);
        word_t offset;
        offset = pc - RESET_PC;
        if (offset < 16'd64) begin
            return i_program[offset[5:0]];
        end
        return '0;
    endfunction

    task automatic check_field(input string field, input word_t expected,
                               input word_t actual);
        if (expected !== actual) begin
            $display("mismatch test %s %s at retirement %0d: expected %h actual %h",
                     test_name, field, retired, expected, actual);
            errors++;
        end
    endtask

    always @(posedge gwe) begin
        reset_seen <= i_reset;
    end

    // sample mid-cycle, the trace changes on rising edges only
    always @(negedge gwe) begin
        logic [39:0] exp;
        word_t       insn;
        if (i_reset) begin
            for (int i = 0; i < 8; i++) begin
                model_regs[i] = '0;
            end
            model_nzp = '0;
            model_pc  = RESET_PC;
            retired   = 0;
            // only once an edge has reset the fetch state
            if (reset_seen && i_imem_req) begin
                $display("instruction request raised while reset is active");
                errors++;
            end
        end else if (i_retire) begin
            insn = program_word(model_pc);
            exp  = predict(insn, model_pc,
                           model_regs[insn[RS_MSB -: 3]],
                           model_regs[insn[RT_MSB -: 3]],
                           model_regs[insn[RD_MSB -: 3]], model_nzp);
            check_field("pc", model_pc, i_retire_pc);
            check_field("insn", insn, i_retire_insn);
            check_field("rf_we", 16'(exp[39]), 16'(i_rf_we));
            if (exp[39]) begin
                check_field("rf_wsel", 16'(exp[38:36]), 16'(i_rf_wsel));
                check_field("rf_data", exp[35:20], i_rf_data);
            end
            check_field("nzp_we", 16'(exp[19]), 16'(i_nzp_we));
            if (exp[19]) begin
                check_field("nzp_bits", 16'(exp[18:16]), 16'(i_nzp_bits));
            end
            // step the model
            if (exp[39]) begin
                model_regs[exp[38:36]] = exp[35:20];
            end
            if (exp[19]) begin
                model_nzp = exp[18:16];
            end
            model_pc = exp[15:0];
            retired++;
        end
    end

endmodule

/* verification/lc4_core_tb.sv */
// ------------------------------------------------
// lc4 core testbench: program image, memory
// responder, directed and random tests
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_core_tb
    import lc4_pkg::*;
;
    localparam word_t RESET_PC = 16'h8200;

    logic     gwe;
    logic     i_reset;
    logic     i_imem_ack;
    word_t    i_imem_data;
    logic     o_imem_req;
    word_t    o_imem_addr;
    logic     o_retire;
    word_t    o_retire_pc;
    word_t    o_retire_insn;
    logic     o_rf_we;
    reg_idx_t o_rf_wsel;
    word_t    o_rf_data;
    logic     o_nzp_we;
    nzp_t     o_nzp_bits;

    word_t       program_mem [64];
    logic [31:0] rng;
    int          ack_delay;
    logic        fast_ack;
    int          tests_run;
    int          tests_failed;
    int          top_errors;

    tb_clock_gen #(.PERIOD(100)) u_clock (.o_clk(gwe), .o_reset(i_reset));

    lc4_core #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(4)) UUT (
        .gwe(gwe), .i_reset(i_reset),
        .i_imem_ack(i_imem_ack), .i_imem_data(i_imem_data),
        .o_imem_req(o_imem_req), .o_imem_addr(o_imem_addr),
        .o_retire(o_retire), .o_retire_pc(o_retire_pc),
        .o_retire_insn(o_retire_insn), .o_rf_we(o_rf_we),
        .o_rf_wsel(o_rf_wsel), .o_rf_data(o_rf_data),
        .o_nzp_we(o_nzp_we), .o_nzp_bits(o_nzp_bits)
    );

    lc4_checker #(.RESET_PC(RESET_PC)) u_checker (
        .gwe(gwe), .i_reset(i_reset), .i_imem_req(o_imem_req),
        .i_retire(o_retire), .i_retire_pc(o_retire_pc),
        .i_retire_insn(o_retire_insn), .i_rf_we(o_rf_we),
        .i_rf_wsel(o_rf_wsel), .i_rf_data(o_rf_data),
        .i_nzp_we(o_nzp_we), .i_nzp_bits(o_nzp_bits),
        .i_program(program_mem)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction encoders
    function automatic word_t enc_const(input int rd, input int imm);
        return {4'b1001, 3'(rd), 9'(imm)};
    endfunction

    function automatic word_t enc_hiconst(input int rd, input int uimm);
        return {4'b1101, 3'(rd), 1'b1, 8'(uimm)};
    endfunction

    function automatic word_t enc_arith(input int rd, input int rs, input int sub,
                                        input int rt);
        return {4'b0001, 3'(rd), 3'(rs), 3'(sub), 3'(rt)};
    endfunction

    function automatic word_t enc_addi(input int rd, input int rs, input int imm);
        return {4'b0001, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
    endfunction

    function automatic word_t enc_logic(input int rd, input int rs, input int sub,
                                        input int rt);
        return {4'b0101, 3'(rd), 3'(rs), 3'(sub), 3'(rt)};
    endfunction

    function automatic word_t enc_br(input int mask, input int off);
        return {4'b0000, 3'(mask), 9'(off)};
    endfunction

    function automatic word_t enc_jmp(input int off);
        return {4'b1100, 1'b1, 11'(off)};
    endfunction

    function automatic word_t memory_word(input word_t addr);
        word_t offset;
        offset = addr - RESET_PC;
        if (offset < 16'd64) begin
            return program_mem[offset[5:0]];
        end
        return '0;
    endfunction

    // memory side of the four-phase handshake, one step per cycle
    always @(posedge gwe) begin
        #10;
        if (i_reset) begin
            i_imem_ack = 1'b0;
            ack_delay  = 0;
        end else if (o_imem_req && !i_imem_ack) begin
            if (ack_delay == 0) begin
                i_imem_data = memory_word(o_imem_addr);
                i_imem_ack  = 1'b1;
            end else begin
                ack_delay--;
            end
        end else if (!o_imem_req && i_imem_ack) begin
            i_imem_ack = 1'b0;
            rng        = xorshift(rng);
            ack_delay  = fast_ack ? 0 : int'(rng % 4);
        end
    end

    task automatic clear_program();
        for (int i = 0; i < 64; i++) begin
            program_mem[i] = '0;
        end
    endtask

    task automatic fill_random_program();
        int kind;
        int off;
        for (int i = 0; i < 63; i++) begin
            rng  = xorshift(rng);
            kind = int'(rng % 8);
            // branch and jump targets stay inside the image
            off  = int'((rng >> 8) % 64) - (i + 1);
            case (kind)
                0: program_mem[i] = enc_const(rng[10:8], rng[24:16]);
                1: program_mem[i] = enc_hiconst(rng[10:8], rng[23:16]);
                2: program_mem[i] = enc_arith(rng[10:8], rng[13:11], rng[17:16] % 3,
                                              rng[20:18]);
                3: program_mem[i] = enc_addi(rng[10:8], rng[13:11], rng[20:16]);
                4: program_mem[i] = enc_logic(rng[10:8], rng[13:11], rng[17:16],
                                              rng[20:18]);
                5: program_mem[i] = enc_br(rng[26:24], off);
                6: program_mem[i] = enc_jmp(off);
                default: program_mem[i] = '0;
            endcase
        end
        program_mem[63] = enc_jmp(-64);
    endtask

    task automatic end_with_timeout(input string what);
        $display("timeout in test %s: %s", u_checker.test_name, what);
        $display("Testbench failed");
        $finish;
    endtask

    // resets the core and waits until the checker has seen n retirements
    task automatic run_test(input string name, input int n);
        int start_errors;
        int cycles;
        start_errors          = u_checker.errors + top_errors;
        u_checker.test_name   = name;
        u_clock.apply_reset();
        cycles = 0;
        while (u_checker.retired < n) begin
            @(posedge gwe);
            cycles++;
            if (cycles > n * 40 + 100) begin
                end_with_timeout("expected retirements did not arrive");
            end
        end
        tests_run++;
        if (u_checker.errors + top_errors != start_errors) begin
            tests_failed++;
        end
        $display("test %s: %0d retirements, %0d errors", name, u_checker.retired,
                 u_checker.errors + top_errors - start_errors);
    endtask

    initial begin
        int cycles;
        i_imem_ack   = 1'b0;
        i_imem_data  = '0;
        rng          = 32'd66;
        ack_delay    = 0;
        fast_ack     = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        top_errors   = 0;
        clear_program();

        // reset state, then the first request must address RESET_PC
        u_checker.test_name = "reset_state";
        u_clock.apply_reset();
        cycles = 0;
        while (!o_imem_req) begin
            @(posedge gwe);
            cycles++;
            if (cycles > 20) begin
                end_with_timeout("no instruction request after reset");
            end
        end
        if (o_imem_addr !== RESET_PC) begin
            $display("mismatch test reset_state imem_addr: expected %h actual %h",
                     RESET_PC, o_imem_addr);
            top_errors++;
        end
        tests_run++;
        tests_failed += (top_errors != 0 || u_checker.errors != 0) ? 1 : 0;
        $display("test reset_state: %0d errors", top_errors + u_checker.errors);

        clear_program();
        program_mem[0]  = enc_const(1, 5);
        program_mem[1]  = enc_const(2, -3);
        program_mem[2]  = enc_hiconst(2, 8'h12);
        program_mem[3]  = enc_arith(3, 1, 0, 2);
        program_mem[4]  = enc_addi(4, 3, -7);
        program_mem[5]  = enc_arith(5, 1, 2, 3);
        program_mem[6]  = enc_arith(6, 1, 1, 2);
        program_mem[7]  = enc_logic(7, 1, 0, 2);
        program_mem[8]  = enc_logic(0, 1, 2, 2);
        program_mem[9]  = enc_logic(3, 3, 3, 3);
        program_mem[10] = enc_logic(4, 1, 1, 0);
        run_test("arith_logic", 11);

        // taken br over two words, untaken br, jmp over two words, loop back
        clear_program();
        program_mem[0] = enc_const(0, -1);
        program_mem[1] = enc_br(3'b100, 2);
        program_mem[2] = enc_const(1, 7);
        program_mem[3] = enc_const(1, 7);
        program_mem[4] = enc_br(3'b010, 1);
        program_mem[5] = enc_jmp(2);
        program_mem[6] = enc_const(2, 9);
        program_mem[7] = enc_const(2, 9);
        program_mem[8] = enc_const(3, 0);
        program_mem[9] = enc_br(3'b010, -10);
        run_test("branch_jump", 12);

        clear_program();
        fast_ack = 1'b1;
        run_test("back_pressure", 100);

        fast_ack = 1'b0;
        fill_random_program();
        run_test("random_program", 300);

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, u_checker.errors + top_errors);
        if (tests_failed == 0 && u_checker.errors == 0 && top_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
// ------------------------------------------------
// testbench clock and reset source
// ------------------------------------------------
`timescale 1ns/1ns
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic o_clk,
    output logic o_reset
);
    initial begin
        o_clk   = 1'b0;
        o_reset = 1'b1;
    end

    always #(PERIOD / 2) o_clk = ~o_clk;

    // reset high across five rising edges, changed just after an edge
    task automatic apply_reset();
        @(posedge o_clk);
        #10;
        o_reset = 1'b1;
        repeat (5) @(posedge o_clk);
        #10;
        o_reset = 1'b0;
    endtask

endmodule

/* verilog/insn_queue.sv */
// ------------------------------------------------
// instruction queue: in-order fifo of insn/pc pairs
// ------------------------------------------------
`timescale 1ns/1ns
module insn_queue
    import lc4_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  gwe,
    input  logic  i_reset,
    input  logic  i_flush,
    input  logic  i_push,
    input  word_t i_insn,
    input  word_t i_pc,
    input  logic  i_pop,
    output logic  o_full,
    output logic  o_valid,
    output word_t o_insn,
    output word_t o_pc
);
    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    word_t            insn_mem [QUEUE_DEPTH];
    word_t            pc_mem   [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // one extra bit so full and empty differ
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign o_full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));
    assign o_valid = (count != '0);
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && o_valid;
    // head is read straight out of the array
    assign o_insn  = insn_mem[rd_ptr];
    assign o_pc    = pc_mem[rd_ptr];

    always_ff @(posedge gwe) begin
        if (i_reset || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge gwe) begin
        if (do_push) begin
            insn_mem[wr_ptr] <= i_insn;
            pc_mem[wr_ptr]   <= i_pc;
        end
    end

endmodule

/* verilog/lc4_alu.sv */
// ------------------------------------------------
// lc4 alu: arithmetic, logic, constants and
// branch/jump targets
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_alu
    import lc4_pkg::*;
(
    input  alu_op_t i_op,
    input  word_t   i_pc,
    input  word_t   i_a,
    input  word_t   i_b,
    input  word_t   i_imm,
    output word_t   o_result
);
    word_t pc_next;
    word_t product;

    assign pc_next = i_pc + 16'd1;
    // low 16 bits of the product only
    assign product = i_a * i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:     o_result = i_a + i_b;
            ALU_SUB:     o_result = i_a - i_b;
            ALU_MUL:     o_result = product;
            ALU_ADDI:    o_result = i_a + i_imm;
            ALU_AND:     o_result = i_a & i_b;
            ALU_OR:      o_result = i_a | i_b;
            ALU_XOR:     o_result = i_a ^ i_b;
            ALU_NOT:     o_result = ~i_a;
            // immediate already sign extended by the decoder
            ALU_CONST:   o_result = i_imm;
            // upper byte from the immediate, lower byte of rd kept
            // rd arrives on the a input
            ALU_HICONST: o_result = {i_imm[7:0], i_a[7:0]};
            // both targets are pc + 1 + offset
            ALU_BRANCH,
            ALU_JUMP:    o_result = pc_next + i_imm;
            default:     o_result = '0;
        endcase
    end

endmodule

/* verilog/lc4_core.sv */
// ------------------------------------------------
// lc4 core top: fetch -> insn queue -> execute
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_core
    import lc4_pkg::*;
#(
    parameter word_t RESET_PC    = 16'h8200,
    parameter int    QUEUE_DEPTH = 4
) (
    input  logic     gwe,
    input  logic     i_reset,
    input  logic     i_imem_ack,
    input  word_t    i_imem_data,
    output logic     o_imem_req,
    output word_t    o_imem_addr,
    output logic     o_retire,
    output word_t    o_retire_pc,
    output word_t    o_retire_insn,
    output logic     o_rf_we,
    output reg_idx_t o_rf_wsel,
    output word_t    o_rf_data,
    output logic     o_nzp_we,
    output nzp_t     o_nzp_bits
);
    // fetch to queue
    logic  f_push;
    word_t f_insn, f_pc;
    // queue to execute
    logic  q_full, q_valid;
    word_t q_insn, q_pc;
    // execute back to queue and fetch
    logic  x_pop, x_redirect;
    word_t x_target;

    lc4_fetch #(.RESET_PC(RESET_PC)) u_fetch (
        .gwe(gwe), .i_reset(i_reset),
        .i_imem_ack(i_imem_ack), .i_imem_data(i_imem_data),
        .i_queue_full(q_full), .i_redirect(x_redirect), .i_target(x_target),
        .o_imem_req(o_imem_req), .o_imem_addr(o_imem_addr),
        .o_push(f_push), .o_insn(f_insn), .o_pc(f_pc)
    );

    // a taken branch or jump empties the queue
    insn_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .gwe(gwe), .i_reset(i_reset), .i_flush(x_redirect),
        .i_push(f_push), .i_insn(f_insn), .i_pc(f_pc), .i_pop(x_pop),
        .o_full(q_full), .o_valid(q_valid), .o_insn(q_insn), .o_pc(q_pc)
    );

    lc4_execute u_execute (
        .gwe(gwe), .i_reset(i_reset),
        .i_valid(q_valid), .i_insn(q_insn), .i_pc(q_pc),
        .o_pop(x_pop), .o_redirect(x_redirect), .o_target(x_target),
        .o_retire(o_retire), .o_retire_pc(o_retire_pc),
        .o_retire_insn(o_retire_insn), .o_rf_we(o_rf_we),
        .o_rf_wsel(o_rf_wsel), .o_rf_data(o_rf_data),
        .o_nzp_we(o_nzp_we), .o_nzp_bits(o_nzp_bits)
    );

endmodule

/* verilog/lc4_decoder.sv */
// ------------------------------------------------
// lc4 decoder: register selects, enables, alu op
// and sign-extended immediate
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_decoder
    import lc4_pkg::*;
(
    input  word_t    i_insn,
    output reg_idx_t o_rs,
    output reg_idx_t o_rt,
    output reg_idx_t o_rd,
    output logic     o_rf_we,
    output logic     o_nzp_we,
    output alu_op_t  o_alu_op,
    output word_t    o_imm,
    output nzp_t     o_br_mask
);
    logic [2:0] subop;

    assign o_rd  = i_insn[RD_MSB -: 3];
    assign o_rs  = i_insn[RS_MSB -: 3];
    assign o_rt  = i_insn[RT_MSB -: 3];
    assign subop = i_insn[SUBOP_MSB -: 3];

    always_comb begin
        // anything not matched below falls out as a nop
        o_rf_we   = 1'b0;
        o_nzp_we  = 1'b0;
        o_alu_op  = ALU_ADD;
        o_imm     = '0;
        o_br_mask = '0;
        case (op_t'(i_insn[INSN_OP_MSB -: 4]))
            OP_BR: begin
                // mask 000 never matches, so it retires as a nop
                o_alu_op  = ALU_BRANCH;
                o_imm     = {{7{i_insn[8]}}, i_insn[8:0]};
                o_br_mask = i_insn[11:9];
            end
            OP_ARITH: begin
                o_rf_we  = 1'b1;
                o_nzp_we = 1'b1;
                o_imm    = {{11{i_insn[4]}}, i_insn[4:0]};
                if (i_insn[5]) begin
                    o_alu_op = ALU_ADDI;
                end else begin
                    case (subop)
                        3'b000:  o_alu_op = ALU_ADD;
                        3'b001:  o_alu_op = ALU_MUL;
                        3'b010:  o_alu_op = ALU_SUB;
                        // div dropped
                        default: begin
                            o_rf_we  = 1'b0;
                            o_nzp_we = 1'b0;
                        end
                    endcase
                end
            end
            OP_LOGIC: begin
                // register forms only, and-immediate is a nop here
                o_rf_we  = 1'b1;
                o_nzp_we = 1'b1;
                case (subop)
                    3'b000:  o_alu_op = ALU_AND;
                    3'b001:  o_alu_op = ALU_NOT;
                    3'b010:  o_alu_op = ALU_OR;
                    3'b011:  o_alu_op = ALU_XOR;
                    default: begin
                        o_rf_we  = 1'b0;
                        o_nzp_we = 1'b0;
                    end
                endcase
            end
            OP_CONST: begin
                o_rf_we  = 1'b1;
                o_nzp_we = 1'b1;
                o_alu_op = ALU_CONST;
                o_imm    = {{7{i_insn[8]}}, i_insn[8:0]};
            end
            OP_HICONST: begin
                o_rf_we  = i_insn[8];
                o_nzp_we = i_insn[8];
                o_alu_op = ALU_HICONST;
                o_imm    = {8'h00, i_insn[7:0]};
            end
            OP_JMP: begin
                // only the pc-relative form, jmpr is a nop
                if (i_insn[11]) begin
                    o_alu_op = ALU_JUMP;
                    o_imm    = {{5{i_insn[10]}}, i_insn[10:0]};
                end
            end
            default: o_alu_op = ALU_ADD;
        endcase
    end

endmodule

/* verilog/lc4_execute.sv */
// ------------------------------------------------
// execute unit: decode, read, compute, nzp, branch
// resolve and the retirement trace
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_execute
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_reset,
    input  logic     i_valid,
    input  word_t    i_insn,
    input  word_t    i_pc,
    output logic     o_pop,
    output logic     o_redirect,
    output word_t    o_target,
    output logic     o_retire,
    output word_t    o_retire_pc,
    output word_t    o_retire_insn,
    output logic     o_rf_we,
    output reg_idx_t o_rf_wsel,
    output word_t    o_rf_data,
    output logic     o_nzp_we,
    output nzp_t     o_nzp_bits
);
    reg_idx_t rs, rt, rd, rs_sel;
    logic     rf_we, nzp_we, br_taken;
    alu_op_t  alu_op;
    word_t    imm, rs_data, rt_data, alu_result;
    nzp_t     br_mask, nzp_q, new_nzp;

    lc4_decoder u_decoder (
        .i_insn(i_insn), .o_rs(rs), .o_rt(rt), .o_rd(rd),
        .o_rf_we(rf_we), .o_nzp_we(nzp_we), .o_alu_op(alu_op),
        .o_imm(imm), .o_br_mask(br_mask)
    );

    // hiconst reads rd so its low byte can be kept
    assign rs_sel = (alu_op == ALU_HICONST) ? rd : rs;

    lc4_regfile u_regfile (
        .gwe(gwe), .i_reset(i_reset), .i_rs(rs_sel), .i_rt(rt), .i_rd(rd),
        .i_we(i_valid && rf_we), .i_wdata(alu_result),
        .o_rs_data(rs_data), .o_rt_data(rt_data)
    );

    lc4_alu u_alu (
        .i_op(alu_op), .i_pc(i_pc), .i_a(rs_data), .i_b(rt_data),
        .i_imm(imm), .o_result(alu_result)
    );

    // one instruction per cycle, the head is always taken
    assign o_pop      = i_valid;
    assign new_nzp    = nzp_of(alu_result);
    assign br_taken   = (alu_op == ALU_BRANCH) && ((br_mask & nzp_q) != '0);
    assign o_redirect = i_valid && (br_taken || (alu_op == ALU_JUMP));
    assign o_target   = alu_result;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_q    <= '0;
            o_retire <= 1'b0;
        end else begin
            o_retire <= i_valid;
            if (i_valid && nzp_we) begin
                nzp_q <= new_nzp;
            end
        end
    end

    // trace payload, meaningful while o_retire is high
    always_ff @(posedge gwe) begin
        if (i_valid) begin
            o_retire_pc   <= i_pc;
            o_retire_insn <= i_insn;
            o_rf_we       <= rf_we;
            o_rf_wsel     <= rd;
            o_rf_data     <= alu_result;
            o_nzp_we      <= nzp_we;
            o_nzp_bits    <= new_nzp;
        end
    end

endmodule

/* verilog/lc4_fetch.sv */
// ------------------------------------------------
// fetch unit: pc register and four-phase req/ack
// handshake with instruction memory
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_fetch
    import lc4_pkg::*;
#(
    parameter word_t RESET_PC = 16'h8200
) (
    input  logic  gwe,
    input  logic  i_reset,
    input  logic  i_imem_ack,
    input  word_t i_imem_data,
    input  logic  i_queue_full,
    input  logic  i_redirect,
    input  word_t i_target,
    output logic  o_imem_req,
    output word_t o_imem_addr,
    output logic  o_push,
    output word_t o_insn,
    output word_t o_pc
);
    fetch_state_t state;
    word_t        pc_q;
    // set when a redirect lands while a request is outstanding
    logic         discard_q;
    logic         capture;
    word_t        next_addr;

    // a redirect seen in idle goes straight out as the next address
    assign next_addr  = i_redirect ? i_target : pc_q;
    assign o_imem_req = (state == F_WAIT_ACK);
    assign capture    = (state == F_WAIT_ACK) && i_imem_ack;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            state       <= F_IDLE;
            pc_q        <= RESET_PC;
            o_imem_addr <= RESET_PC;
            discard_q   <= 1'b0;
            o_push      <= 1'b0;
        end else begin
            o_push <= 1'b0;
            if (i_redirect) begin
                pc_q <= i_target;
            end
            case (state)
                F_IDLE: begin
                    // back-pressure, a full queue holds us here
                    // a redirect flushes the queue on this edge
                    if (!i_queue_full || i_redirect) begin
                        o_imem_addr <= next_addr;
                        state       <= F_WAIT_ACK;
                    end
                end
                F_WAIT_ACK: begin
                    if (i_imem_ack) begin
                        state     <= F_WAIT_RELEASE;
                        discard_q <= 1'b0;
                        // stale word after a redirect is dropped
                        if (!discard_q && !i_redirect) begin
                            o_push <= 1'b1;
                            pc_q   <= o_imem_addr + 16'd1;
                        end
                    end else if (i_redirect) begin
                        discard_q <= 1'b1;
                    end
                end
                F_WAIT_RELEASE: begin
                    // memory must drop ack before the next req
                    if (!i_imem_ack) begin
                        state <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // word and its address, valid with o_push
    always_ff @(posedge gwe) begin
        if (capture) begin
            o_insn <= i_imem_data;
            o_pc   <= o_imem_addr;
        end
    end

endmodule

/* verilog/lc4_pkg.sv */
// ------------------------------------------------
// lc4 shared types: words, register numbers, nzp,
// opcode and alu enums, field positions
// ------------------------------------------------
package lc4_pkg;

    // data, pc and instruction words are all 16 bits
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    // n z p, one hot
    typedef logic [2:0]  nzp_t;

    // major opcode field, bits 15:12
    typedef enum logic [3:0] {
        OP_BR      = 4'b0000,
        OP_ARITH   = 4'b0001,
        OP_LOGIC   = 4'b0101,
        OP_CONST   = 4'b1001,
        OP_JMP     = 4'b1100,
        OP_HICONST = 4'b1101
    } op_t;

    // operations the alu knows about
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_ADDI,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
        ALU_CONST, ALU_HICONST, ALU_BRANCH, ALU_JUMP
    } alu_op_t;

    // four-phase handshake with instruction memory
    typedef enum logic [1:0] {
        F_IDLE, F_WAIT_ACK, F_WAIT_RELEASE
    } fetch_state_t;

    // msb of each instruction field
    localparam int INSN_OP_MSB = 15;
    localparam int RD_MSB      = 11;
    localparam int RS_MSB      = 8;
    localparam int SUBOP_MSB   = 5;
    localparam int RT_MSB      = 2;

    // condition code of a signed value
    function automatic nzp_t nzp_of(input word_t value);
        return value[15] ? 3'b100 : ((value == '0) ? 3'b010 : 3'b001);
    endfunction

endpackage

/* verilog/lc4_regfile.sv */
// ------------------------------------------------
// register file: 8 x 16, two async reads, one write
// ------------------------------------------------
`timescale 1ns/1ns
module lc4_regfile
    import lc4_pkg::*;
(
    input  logic     gwe,
    input  logic     i_reset,
    input  reg_idx_t i_rs,
    input  reg_idx_t i_rt,
    input  reg_idx_t i_rd,
    input  logic     i_we,
    input  word_t    i_wdata,
    output word_t    o_rs_data,
    output word_t    o_rt_data
);
    word_t regs [8];

    // reads see the old value until the write edge
    assign o_rs_data = regs[i_rs];
    assign o_rt_data = regs[i_rt];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

/* vlog.f */
verilog/lc4_pkg.sv
verilog/lc4_fetch.sv
verilog/insn_queue.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_alu.sv
verilog/lc4_execute.sv
verilog/lc4_core.sv
verification/tb_clock_gen.sv
verification/lc4_checker.sv
verification/lc4_core_tb.sv
